//--- hw/coreTypes.sv
package coreTypes;

  localparam int defRamDepthLog2 = 8;  // 256-word data RAM

  // Register-form primary opcodes
  typedef enum logic [5:0] {
    opAdd   = 6'o00,
    opRsub  = 6'o01,
    opBsf   = 6'o21,
    opOr    = 6'o40,
    opAnd   = 6'o41,
    opXor   = 6'o42,
    opLoad  = 6'o62,
    opStore = 6'o66
  } opcodeT;

  localparam logic [5:0] opFormMask = 6'o67;  // Clears the immediate-form bit

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [10:0] alt;  // Bit 10 picks a left barrel shift
  } regFormT;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [15:0] imm;
  } immFormT;

  typedef union packed {
    regFormT regForm;
    immFormT immForm;
  } instWordT;

  typedef enum logic [1:0] {
    srcReg  = 2'd0,
    srcFwdX = 2'd1,  // ALU result of the instruction ahead
    srcFwdR = 2'd2,  // RAM read data of a load ahead
    srcImm  = 2'd3
  } srcSelT;

  typedef enum logic [2:0] {
    fnAdd   = 3'd0,
    fnRsub  = 3'd1,
    fnOr    = 3'd2,
    fnAnd   = 3'd3,
    fnXor   = 3'd4,
    fnShift = 3'd5
  } aluFnT;

  typedef enum logic [1:0] {
    dstAlu  = 2'd0,
    dstMem  = 2'd2,
    dstNone = 2'd3
  } dstSelT;

  // Decode to execute
  typedef struct packed {
    aluFnT       aluFn;
    srcSelT      srcA;
    srcSelT      srcB;
    dstSelT      dst;
    logic [4:0]  rw;
    logic        isStore;
    logic        isShift;
    logic        shiftLeft;
    logic [31:0] imm32;
  } ctrlX;

  // Execute to writeback
  typedef struct packed {
    dstSelT      dst;
    logic [4:0]  rw;
    logic        rdwe;
    logic [31:0] result;
  } ctrlR;

endpackage

//--- hw/regFile.sv
`timescale 1ns/1ns

module regFile (
  input  logic        gclk,
  input  logic [4:0]  rdA,
  input  logic [4:0]  rdB,
  output logic [31:0] dataA,
  output logic [31:0] dataB,
  input  logic        wrEn,
  input  logic [4:0]  wrAddr,
  input  logic [31:0] wrData
);

  logic [31:0] regs [32];

  always_ff @(posedge gclk) begin
    if (wrEn && (wrAddr != 5'd0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // r0 is hardwired
  assign dataA = (rdA == 5'd0) ? 32'd0 : regs[rdA];
  assign dataB = (rdB == 5'd0) ? 32'd0 : regs[rdB];

endmodule

//--- hw/dataRam.sv
`timescale 1ns/1ns

module dataRam import coreTypes::*; #(
  parameter int ramDepthLog2 = defRamDepthLog2
) (
  input  logic        gclk,
  input  logic        we,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  logic [31:0]             mem [2**ramDepthLog2];
  logic [ramDepthLog2-1:0] wordAddr;

  assign wordAddr = addr[ramDepthLog2+1:2];  // Word index

  // Read is registered so data lands in writeback
  always_ff @(posedge gclk) begin
    if (we) begin
      mem[wordAddr] <= wdata;
    end
    rdata <= mem[wordAddr];
  end

endmodule

//--- hw/execUnit.sv
`timescale 1ns/1ns

module execUnit import coreTypes::*; (
  input  logic        gclk,
  input  logic        rst,
  input  ctrlX        ctrl,
  input  logic [31:0] regA,
  input  logic [31:0] regB,
  input  logic [31:0] fwdX,
  input  logic [31:0] fwdR,
  input  logic [1:0]  shiftStep,
  output logic [31:0] result,
  output logic [31:0] storeData
);

  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] aluB;
  logic [31:0] aluOut;
  logic [31:0] stepIn;
  logic [31:0] stepMid;
  logic [31:0] stepOut;
  logic [31:0] partial;  // Shifter value between steps
  logic [4:0]  amt;
  logic [4:0]  amtReg;

  function automatic logic [31:0] shiftBy(
    input logic [31:0] v,
    input logic        left,
    input logic        en,
    input int unsigned n
  );
    logic [31:0] r;
    if (!en) begin
      r = v;
    end else if (left) begin
      r = v << n;
    end else begin
      r = v >> n;
    end
    return r;
  endfunction

  always_comb begin
    case (ctrl.srcA)
      srcFwdX: opA = fwdX;
      srcFwdR: opA = fwdR;
      default: opA = regA;
    endcase
    case (ctrl.srcB)
      srcFwdX: opB = fwdX;
      srcFwdR: opB = fwdR;
      srcImm:  opB = ctrl.imm32;
      default: opB = regB;
    endcase
  end

  assign aluB = ctrl.isStore ? ctrl.imm32 : opB;  // Store offset while B carries data

  always_comb begin
    case (ctrl.aluFn)
      fnRsub:  aluOut = aluB - opA;
      fnOr:    aluOut = opA | aluB;
      fnAnd:   aluOut = opA & aluB;
      fnXor:   aluOut = opA ^ aluB;
      default: aluOut = opA + aluB;  // Add and load/store address
    endcase
  end

  // Step 1 works on the live operands and later steps on the saved ones
  assign stepIn = (shiftStep == 2'd1) ? opA : partial;
  assign amt    = (shiftStep == 2'd1) ? opB[4:0] : amtReg;

  always_comb begin
    stepMid = stepIn;
    stepOut = stepIn;
    case (shiftStep)
      2'd1: begin
        stepMid = shiftBy(stepIn, ctrl.shiftLeft, amt[4], 16);
        stepOut = shiftBy(stepMid, ctrl.shiftLeft, amt[3], 8);
      end
      2'd2: begin
        stepMid = shiftBy(stepIn, ctrl.shiftLeft, amt[2], 4);
        stepOut = shiftBy(stepMid, ctrl.shiftLeft, amt[1], 2);
      end
      default: stepOut = shiftBy(stepIn, ctrl.shiftLeft, amt[0], 1);
    endcase
  end

  always_ff @(posedge gclk) begin
    if (rst) begin
      partial <= 32'd0;
      amtReg  <= 5'd0;
    end else begin
      if ((shiftStep == 2'd1) || (shiftStep == 2'd2)) begin
        partial <= stepOut;
      end
      if (shiftStep == 2'd1) begin
        amtReg <= opB[4:0];  // RAM forward source changes after step 1
      end
    end
  end

  assign result    = ctrl.isShift ? stepOut : aluOut;
  assign storeData = opB;

endmodule

//--- hw/issueSequencer.sv
`timescale 1ns/1ns

module issueSequencer (
  input  logic       gclk,
  input  logic       rst,
  input  logic       isShiftD,
  output logic       pipeEn,
  output logic [1:0] shiftStep,
  output logic       stall
);

  // State value doubles as the shifter step number
  typedef enum logic [1:0] {
    stIdle  = 2'd0,
    stStep1 = 2'd1,
    stStep2 = 2'd2,
    stDrain = 2'd3
  } seqStateT;

  seqStateT state;
  seqStateT nextState;

  always_comb begin
    nextState = state;
    case (state)
      stIdle: begin
        if (isShiftD) begin
          nextState = stStep1;  // Shift moves into execute
        end
      end
      stStep1: nextState = stStep2;
      stStep2: nextState = stDrain;
      stDrain: nextState = isShiftD ? stStep1 : stIdle;
      default: nextState = stIdle;
    endcase
  end

  always_ff @(posedge gclk) begin
    if (rst) begin
      state <= stIdle;
    end else begin
      state <= nextState;
    end
  end

  // Frozen for the first two shift steps
  assign pipeEn    = (state != stStep1) && (state != stStep2);
  assign shiftStep = state;
  assign stall     = isShiftD || (state != stIdle);

endmodule

//--- hw/instDecoder.sv
`timescale 1ns/1ns

module instDecoder import coreTypes::*; (
  input  logic        gclk,
  input  logic        rst,
  input  logic        pipeEn,
  input  logic        instValid,
  input  instWordT    instWord,
  output logic [4:0]  rdA,
  output logic [4:0]  rdB,
  input  logic [31:0] exResult,
  input  logic [31:0] ramData,
  output ctrlX        ctrlXOut,
  output logic        isShiftD,
  output logic        wbValid,
  output logic [4:0]  wbReg,
  output logic [31:0] wbData
);

  logic        dValid;
  instWordT    dInst;
  opcodeT      baseOp;
  logic        isImm;
  aluFnT       decFn;
  dstSelT      decDst;
  logic        decStore;
  logic [4:0]  srcRegB;
  logic        xWrites;
  ctrlX        dCtrl;
  ctrlX        xCtrl;
  logic [4:0]  xRa;
  logic [4:0]  xRb;
  ctrlR        rCtrl;

  assign baseOp = opcodeT'(dInst.regForm.opcode & opFormMask);
  assign isImm  = dInst.regForm.opcode[3];

  always_comb begin
    decFn    = fnAdd;
    decDst   = dstAlu;
    decStore = 1'b0;
    case (baseOp)
      opAdd:   decFn = fnAdd;
      opRsub:  decFn = fnRsub;
      opOr:    decFn = fnOr;
      opAnd:   decFn = fnAnd;
      opXor:   decFn = fnXor;
      opBsf:   decFn = fnShift;
      opLoad:  decDst = dstMem;  // Address through the adder
      opStore: begin
        decDst   = dstNone;
        decStore = 1'b1;
      end
      default: decDst = dstNone;  // Unknown opcode acts as a no-op
    endcase
  end

  // Port B reads rd for a store since that register holds the data
  assign srcRegB  = decStore ? dInst.regForm.rd : dInst.regForm.rb;
  assign xWrites  = (xCtrl.dst != dstNone) && (xCtrl.rw != 5'd0);
  assign isShiftD = dValid && (baseOp == opBsf);

  always_comb begin
    dCtrl.aluFn     = decFn;
    dCtrl.dst       = dValid ? decDst : dstNone;
    dCtrl.rw        = dInst.regForm.rd;
    dCtrl.isStore   = dValid && decStore;
    dCtrl.isShift   = isShiftD;
    dCtrl.shiftLeft = dInst.regForm.alt[10];
    dCtrl.imm32     = isImm ? {{16{dInst.immForm.imm[15]}}, dInst.immForm.imm} : 32'd0;

    dCtrl.srcA = srcReg;
    if (xWrites && (xCtrl.rw == dInst.regForm.ra)) begin
      dCtrl.srcA = (xCtrl.dst == dstMem) ? srcFwdR : srcFwdX;
    end

    if (isImm && !decStore) begin
      dCtrl.srcB = srcImm;
    end else if (xWrites && (xCtrl.rw == srcRegB)) begin
      dCtrl.srcB = (xCtrl.dst == dstMem) ? srcFwdR : srcFwdX;
    end else begin
      dCtrl.srcB = srcReg;
    end
  end

  // Decode and execute control
  always_ff @(posedge gclk) begin
    if (rst) begin
      dValid        <= 1'b0;
      xCtrl.dst     <= dstNone;
      xCtrl.isStore <= 1'b0;
      xCtrl.isShift <= 1'b0;
    end else if (pipeEn) begin
      dValid <= instValid;
      xCtrl  <= dCtrl;
    end
  end

  always_ff @(posedge gclk) begin
    if (pipeEn) begin
      dInst <= instWord;
      xRa   <= dInst.regForm.ra;
      xRb   <= srcRegB;
    end
  end

  assign rdA      = xRa;  // Register file is read in execute
  assign rdB      = xRb;
  assign ctrlXOut = xCtrl;

  // Writeback strobe drops while the pipe is frozen
  always_ff @(posedge gclk) begin
    if (rst) begin
      rCtrl.rdwe <= 1'b0;
    end else begin
      rCtrl.rdwe <= pipeEn && xWrites;
    end
  end

  always_ff @(posedge gclk) begin
    if (pipeEn) begin
      rCtrl.dst    <= xCtrl.dst;
      rCtrl.rw     <= xCtrl.rw;
      rCtrl.result <= exResult;
    end
  end

  assign wbValid = rCtrl.rdwe;
  assign wbReg   = rCtrl.rw;
  assign wbData  = (rCtrl.dst == dstMem) ? ramData : rCtrl.result;

endmodule

//--- hw/pipeCore.sv
`timescale 1ns/1ns

module pipeCore import coreTypes::*; #(
  parameter int ramDepthLog2 = defRamDepthLog2
) (
  input  logic        gclk,
  input  logic        rst,
  input  logic        instValid,
  input  instWordT    instWord,
  output logic        stall,
  output logic        wbValid,
  output logic [4:0]  wbReg,
  output logic [31:0] wbData
);

  logic        pipeEn;
  logic        isShiftD;
  logic [1:0]  shiftStep;
  logic [4:0]  rdA;
  logic [4:0]  rdB;
  logic [31:0] dataA;
  logic [31:0] dataB;
  ctrlX        xCtrl;
  logic [31:0] exResult;
  logic [31:0] storeData;
  logic [31:0] ramData;

  instDecoder decoder (
    .gclk      (gclk),
    .rst       (rst),
    .pipeEn    (pipeEn),
    .instValid (instValid),
    .instWord  (instWord),
    .rdA       (rdA),
    .rdB       (rdB),
    .exResult  (exResult),
    .ramData   (ramData),
    .ctrlXOut  (xCtrl),
    .isShiftD  (isShiftD),
    .wbValid   (wbValid),
    .wbReg     (wbReg),
    .wbData    (wbData)
  );

  issueSequencer sequencer (
    .gclk      (gclk),
    .rst       (rst),
    .isShiftD  (isShiftD),
    .pipeEn    (pipeEn),
    .shiftStep (shiftStep),
    .stall     (stall)
  );

  regFile regs (
    .gclk   (gclk),
    .rdA    (rdA),
    .rdB    (rdB),
    .dataA  (dataA),
    .dataB  (dataB),
    .wrEn   (wbValid),
    .wrAddr (wbReg),
    .wrData (wbData)
  );

  // Writeback value feeds the ALU forward path
  execUnit exec (
    .gclk      (gclk),
    .rst       (rst),
    .ctrl      (xCtrl),
    .regA      (dataA),
    .regB      (dataB),
    .fwdX      (wbData),
    .fwdR      (ramData),
    .shiftStep (shiftStep),
    .result    (exResult),
    .storeData (storeData)
  );

  dataRam #(
    .ramDepthLog2 (ramDepthLog2)
  ) ram (
    .gclk  (gclk),
    .we    (xCtrl.isStore),
    .addr  (exResult),
    .wdata (storeData),
    .rdata (ramData)
  );

endmodule

//--- sim/pipeCore_chk.sv
`timescale 1ns/1ns

module pipeCore_chk (
  input logic       gclk,
  input logic       rst,
  input logic       stall,
  input logic       wbValid,
  input logic [4:0] wbReg
);

  logic [2:0] stallRun;  // Stalled samples so far
  int         assertFails = 0;

  always_ff @(posedge gclk) begin
    if (rst) begin
      stallRun <= 3'd0;
    end else if (!stall) begin
      stallRun <= 3'd0;
    end else if (stallRun != 3'd7) begin
      stallRun <= stallRun + 3'd1;
    end
  end

  quietAfterReset: assert property (@(posedge gclk) $fell(rst) |-> !wbValid)
    else begin
      assertFails++;
      $error("wbValid high in the first cycle after reset");
    end

  // Shift holds the pipe for four cycles at most
  stallBound: assert property (@(posedge gclk) disable iff (rst) stall |-> (stallRun < 3'd4))
    else begin
      assertFails++;
      $error("stall held longer than four cycles");
    end

  noZeroWrite: assert property (@(posedge gclk) disable iff (rst) wbValid |-> (wbReg != 5'd0))
    else begin
      assertFails++;
      $error("writeback to register zero");
    end

endmodule

bind pipeCore pipeCore_chk chk (
  .gclk    (gclk),
  .rst     (rst),
  .stall   (stall),
  .wbValid (wbValid),
  .wbReg   (wbReg)
);

//--- sim/pipeCoreTb.sv
`timescale 1ns/1ns

module pipeCoreTb import coreTypes::*; ();

  localparam int ramDepthLog2 = 8;

  // One pending writeback of the reference model
  typedef struct {
    string       name;
    logic [4:0]  rd;
    logic [31:0] data;
    int          due;
  } wbExpT;

  logic        gclk;
  logic        rst;
  logic        instValid;
  instWordT    instWord;
  logic        stall;
  logic        wbValid;
  logic [4:0]  wbReg;
  logic [31:0] wbData;

  logic [31:0] shadowRegs [32];
  logic [31:0] shadowMem [2**ramDepthLog2];
  wbExpT       expQ [$];
  wbExpT       seen;
  string       testName;
  int          cycle;
  int          mismatches;
  int          failures;
  integer      seed;

  pipeCore #(
    .ramDepthLog2 (ramDepthLog2)
  ) UUT (
    .gclk      (gclk),
    .rst       (rst),
    .instValid (instValid),
    .instWord  (instWord),
    .stall     (stall),
    .wbValid   (wbValid),
    .wbReg     (wbReg),
    .wbData    (wbData)
  );

  always #20 gclk = ~gclk;

  always @(posedge gclk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [15:0] rand16();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  function automatic logic [4:0] randSmall(input int base, input int span);
    logic [31:0] r;
    r = $random(seed);
    return 5'(base + int'(r[7:0]) % span);
  endfunction

  function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic instWordT regInst(
    input opcodeT     op,
    input logic [4:0] rd,
    input logic [4:0] ra,
    input logic [4:0] rb,
    input logic       left
  );
    instWordT w;
    w.regForm.opcode = op;
    w.regForm.rd     = rd;
    w.regForm.ra     = ra;
    w.regForm.rb     = rb;
    w.regForm.alt    = {left, 10'd0};
    return w;
  endfunction

  function automatic instWordT immInst(
    input opcodeT      op,
    input logic [4:0]  rd,
    input logic [4:0]  ra,
    input logic [15:0] imm
  );
    instWordT w;
    w.immForm.opcode = op | 6'o10;  // Immediate form
    w.immForm.rd     = rd;
    w.immForm.ra     = ra;
    w.immForm.imm    = imm;
    return w;
  endfunction

  task automatic compareReg(input string name, input logic [4:0] exp, input logic [4:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch in %s: wbReg expected %0d, got %0d", name, exp, act);
    end
  endtask

  task automatic compareData(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch in %s: wbData expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic compareFlag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch in %s: stall expected %b, got %b", name, exp, act);
    end
  endtask

  task automatic compareCount(input string name, input int exp, input int act);
    if (act != exp) begin
      mismatches++;
      $display("Mismatch in %s: writeback cycle expected %0d, got %0d", name, exp, act);
    end
  endtask

  // Writeback monitor, sampled mid-cycle
  always @(negedge gclk) begin
    if (!rst && wbValid) begin
      if (expQ.size() == 0) begin
        failures++;
        $display("Unexpected writeback to r%0d during %s", wbReg, testName);
      end else begin
        seen = expQ.pop_front();
        compareReg(seen.name, seen.rd, wbReg);
        compareData(seen.name, seen.data, wbData);
        compareCount(seen.name, seen.due, cycle);
      end
    end else if (!rst && expQ.size() != 0 && cycle >= expQ[0].due) begin
      seen = expQ.pop_front();
      failures++;
      $display("No writeback to r%0d in %s by cycle %0d", seen.rd, seen.name, seen.due);
    end
  end

  // Issue one instruction and predict its writeback
  task automatic issue(input instWordT w);
    logic [5:0]  base;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] addr;
    logic        writes;
    int          lat;
    int          guard;
    wbExpT       e;
    guard = 0;
    while (stall && guard < 8) begin  // Shift still in the pipe
      @(posedge gclk);
      #5;
      guard++;
    end
    if (stall) begin
      failures++;
      $display("Timeout in %s, stall never fell", testName);
    end
    base   = w.regForm.opcode & 6'o67;
    a      = shadowRegs[w.regForm.ra];
    b      = w.regForm.opcode[3] ? sext16(w.immForm.imm) : shadowRegs[w.regForm.rb];
    addr   = a + b;
    writes = 1'b1;
    lat    = 3;
    case (base)
      opAdd:  r = a + b;
      opRsub: r = b - a;
      opOr:   r = a | b;
      opAnd:  r = a & b;
      opXor:  r = a ^ b;
      opLoad: r = shadowMem[addr[ramDepthLog2+1:2]];
      opBsf: begin
        r   = w.regForm.alt[10] ? a << b[4:0] : a >> b[4:0];
        lat = 5;  // Two frozen cycles
      end
      default: begin  // Store, immediate form only
        r      = 32'd0;
        writes = 1'b0;
        shadowMem[addr[ramDepthLog2+1:2]] = shadowRegs[w.regForm.rd];
      end
    endcase
    instWord  = w;
    instValid = 1'b1;
    if (writes && (w.regForm.rd != 5'd0)) begin
      shadowRegs[w.regForm.rd] = r;
      e.name = testName;
      e.rd   = w.regForm.rd;
      e.data = r;
      e.due  = cycle + lat;
      expQ.push_back(e);
    end
    @(posedge gclk);
    #5;
    instValid = 1'b0;
  endtask

  task automatic drainPipe();
    int guard;
    guard = 0;
    while (expQ.size() != 0 && guard < 12) begin
      @(posedge gclk);
      #5;
      guard++;
    end
    if (expQ.size() != 0) begin
      failures++;
      $display("Timeout in %s, %0d writebacks never arrived", testName, expQ.size());
      expQ.delete();
    end
  endtask

  task automatic aluRegTest();
    opcodeT ops [5];
    ops = '{opAdd, opRsub, opOr, opAnd, opXor};
    testName = "register ALU";
    for (int r = 1; r < 16; r++) begin
      issue(immInst(opAdd, 5'(r), 5'd0, rand16()));
    end
    for (int i = 0; i < 15; i++) begin
      issue(regInst(ops[i % 5], randSmall(5, 8), randSmall(1, 12), randSmall(1, 12), 1'b0));
    end
    drainPipe();
  endtask

  task automatic aluImmTest();
    opcodeT ops [5];
    ops = '{opAdd, opRsub, opOr, opAnd, opXor};
    testName = "negative immediate";
    for (int i = 0; i < 10; i++) begin
      issue(immInst(ops[i % 5], randSmall(5, 8), randSmall(1, 12), rand16() | 16'h8000));
    end
    drainPipe();
  endtask

  task automatic forwardTest();
    testName = "forwarding";
    issue(immInst(opAdd, 5'd1, 5'd0, rand16()));
    issue(regInst(opAdd, 5'd2, 5'd1, 5'd1, 1'b0));   // Back-to-back on r1
    issue(regInst(opXor, 5'd3, 5'd2, 5'd1, 1'b0));   // r1 now two apart
    issue(regInst(opRsub, 5'd4, 5'd3, 5'd2, 1'b0));
    issue(immInst(opOr, 5'd5, 5'd4, rand16()));
    issue(regInst(opAnd, 5'd6, 5'd5, 5'd4, 1'b0));
    issue(regInst(opAdd, 5'd7, 5'd0, 5'd5, 1'b0));
    drainPipe();
  endtask

  task automatic memoryTest();
    logic [15:0] v;
    testName = "store and load";
    for (int i = 0; i < 2; i++) begin
      v = rand16();
      issue(immInst(opAdd, 5'd10, 5'd0, {6'd0, v[7:0], 2'b00}));  // Word aligned base
      issue(immInst(opAdd, 5'd11, 5'd0, rand16()));
      issue(immInst(opStore, 5'd11, 5'd10, 16'd8));
      issue(immInst(opLoad, 5'd12, 5'd10, 16'd8));
      issue(regInst(opAdd, 5'd13, 5'd12, 5'd11, 1'b0));  // Load use
      issue(immInst(opStore, 5'd13, 5'd10, 16'hfffc));
      issue(immInst(opLoad, 5'd14, 5'd10, 16'hfffc));
    end
    drainPipe();
  endtask

  task automatic shiftTest();
    logic       left;
    logic [4:0] amt;
    testName = "barrel shift";
    for (int i = 0; i < 8; i++) begin
      left = i[0];
      amt  = randSmall(0, 32);
      issue(immInst(opBsf, randSmall(5, 4), randSmall(1, 8), {5'd0, left, 5'd0, amt}));
      compareFlag("barrel shift", 1'b1, stall);
    end
    issue(immInst(opAdd, 5'd8, 5'd0, {11'd0, randSmall(0, 32)}));
    issue(regInst(opBsf, 5'd9, 5'd1, 5'd8, 1'b1));  // Amount forwarded
    compareFlag("register shift", 1'b1, stall);
    drainPipe();
    compareFlag("after shift", 1'b0, stall);
  endtask

  task automatic zeroRegTest();
    testName = "register zero";
    issue(immInst(opAdd, 5'd0, 5'd1, rand16()));
    issue(regInst(opOr, 5'd0, 5'd2, 5'd3, 1'b0));
    issue(regInst(opAdd, 5'd5, 5'd0, 5'd3, 1'b0));
    issue(immInst(opXor, 5'd6, 5'd0, 16'h1234));
    drainPipe();
  endtask

  initial begin
    seed       = 19;
    gclk       = 1'b0;
    rst        = 1'b1;
    instValid  = 1'b0;
    instWord   = '0;
    cycle      = 0;
    mismatches = 0;
    failures   = 0;
    testName   = "reset";
    for (int i = 0; i < 32; i++) begin
      shadowRegs[i] = 32'd0;
    end
    repeat (16) @(posedge gclk);
    #5;
    rst = 1'b0;
    aluRegTest();
    aluImmTest();
    forwardTest();
    memoryTest();
    shiftTest();
    zeroRegTest();
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, UUT.chk.assertFails);
    if (mismatches + failures + UUT.chk.assertFails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Hang guard
  initial begin
    #200000;
    $display("Simulation timed out, pipeline stopped responding");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- src.f
hw/coreTypes.sv
hw/regFile.sv
hw/dataRam.sv
hw/execUnit.sv
hw/issueSequencer.sv
hw/instDecoder.sv
hw/pipeCore.sv
sim/pipeCore_chk.sv
sim/pipeCoreTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pipeCoreTb
FILELIST  = src.f
OBJDIR    = obj_dir
RUNFLAGS  = +verilator+error+limit+1000
PASSTEXT  = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$($(OBJDIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
